// ==== verilog.f ====
verilog/card_pkg.sv
verilog/player_pkg.sv
verilog/hand_bank.sv
verilog/hand_cursor.sv
verilog/turn_ctrl.sv
verilog/uno_player.sv
sim/tb_clock_gen.sv
sim/tb_uno_player.sv

// ==== sim/tb_uno_player.sv ====
module tb_uno_player;
    import card_pkg::*;

    typedef enum logic [2:0] {OP_DEAL, OP_START, OP_PRESS, OP_SELECT, OP_ACK, OP_CHECK} op_e;

    typedef struct packed {
        op_e         op;
        logic [2:0]  arg;        // penalty count on start or 1 for right on press
        logic [3:0]  hold;       // cycles held or waited
        card_t       prev;
        card_t [0:6] deck;       // 3f ends the list
        logic        exp_out;
        count_t      exp_index;
    } step_t;

    localparam int NUM_STEPS     = 30;
    localparam int DRAW_TIMEOUT  = 100;
    localparam int RESET_TIMEOUT = 20;

    localparam card_t [0:6] NO_DECK   = {7{6'h3f}};
    localparam card_t [0:6] DECK_DEAL = {6'h33, 6'h05, 6'h0d, 6'h17, 6'h22, 6'h0e, 6'h09};
    localparam card_t [0:6] DECK_TWO  = {6'h28, 6'h01, {5{6'h3f}}};
    localparam card_t [0:6] DECK_ONE  = {6'h14, {6{6'h3f}}};
    localparam card_t [0:6] DECK_FOUR = {6'h30, 6'h0d, 6'h07, 6'h12, {3{6'h3f}}};
    localparam card_t [0:6] DECK_FILL = {6'h19, 6'h0d, 6'h3a, 6'h25, 6'h06, 6'h2b, 6'h1c};

    logic   i_clk;
    logic   i_rst_n;
    logic   i_init;
    logic   i_start;
    logic   i_draw_two;
    logic   i_draw_four;
    logic   i_select;
    logic   i_left;
    logic   i_right;
    logic   i_drawn;
    logic   i_out_ack;
    card_t  i_prev_card;
    card_t  i_drawn_card;
    logic   o_draw;
    logic   o_out;
    card_t  o_out_card;
    hand_t  o_hands;
    logic   o_full;
    count_t o_index;

    step_t  steps [NUM_STEPS];
    card_t  deck_q [$];
    card_t  hand_q [$];      // expected hand from slot 0 up
    count_t cur_index;
    logic   out_now;
    card_t  exp_card;
    integer seed = 32'h2f78;

    tb_clock_gen u_clock_gen (
        .o_clk   (i_clk),
        .o_rst_n (i_rst_n)
    );

    uno_player #(
        .HAND_SIZE  (HAND_MAX),
        .INIT_CARDS (7)
    ) dut0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_select     (i_select),
        .i_left       (i_left),
        .i_right      (i_right),
        .i_drawn      (i_drawn),
        .i_out_ack    (i_out_ack),
        .i_prev_card  (i_prev_card),
        .i_drawn_card (i_drawn_card),
        .o_draw       (o_draw),
        .o_out        (o_out),
        .o_out_card   (o_out_card),
        .o_hands      (o_hands),
        .o_full       (o_full),
        .o_index      (o_index)
    );

    // deck hands out one queued card per pulse after a short random gap
    initial begin : deck_model
        int gap;
        gap          = 0;
        i_drawn      = 1'b0;
        i_drawn_card = CARD_NONE;
        forever begin
            @(posedge i_clk);
            i_drawn <= 1'b0;
            if (o_draw && !i_drawn && deck_q.size() > 0) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    i_drawn      <= 1'b1;
                    i_drawn_card <= deck_q.pop_front();
                    gap = $unsigned($random(seed)) % 3;
                end
            end
        end
    end

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_card(string name, card_t got, card_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_hand(string name, hand_t got, hand_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_count(string name, count_t got, count_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s = %0d, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s = %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    // display order red, yellow, green, blue, wild, wild draw four
    function automatic int display_rank(card_t c);
        case (c.value)
            VAL_WILD:  return 4;
            VAL_WILD4: return 5;
            default:   return int'(c.colour);
        endcase
    endfunction

    task automatic model_insert(card_t c);
        int pos;
        pos = 0;
        if (hand_q.size() < HAND_MAX) begin
            foreach (hand_q[i]) begin
                if (display_rank(hand_q[i]) <= display_rank(c)) begin
                    pos = i + 1;  // end of its group
                end
            end
            hand_q.insert(pos, c);
        end
    endtask

    function automatic hand_t model_hand();
        hand_t h;
        for (int i = 0; i < HAND_MAX; i++) begin
            h[i] = (i < hand_q.size()) ? hand_q[i] : CARD_NONE;
        end
        return h;
    endfunction

    task automatic wait_draw_idle();
        int n;
        n = 0;
        @(negedge i_clk);
        while (o_draw) begin
            if (n == DRAW_TIMEOUT) begin
                stop_with_failure("deck draw did not finish in time");
            end
            n++;
            @(negedge i_clk);
        end
    endtask

    task automatic apply_step(step_t s);
        logic expect_draw;
        deck_q.delete();
        for (int k = 0; k < 7; k++) begin
            if (s.deck[k] != CARD_NONE) begin
                deck_q.push_back(s.deck[k]);
            end
        end
        expect_draw = (deck_q.size() > 0);
        @(posedge i_clk);
        case (s.op)
            OP_DEAL:  i_init <= 1'b1;
            OP_START: begin
                i_start     <= 1'b1;
                i_draw_two  <= (s.arg == 3'd2);
                i_draw_four <= (s.arg == 3'd4);
            end
            OP_PRESS: begin
                if (s.arg[0]) begin
                    i_right <= 1'b1;
                end else begin
                    i_left <= 1'b1;
                end
            end
            OP_SELECT: begin
                i_prev_card <= s.prev;
                i_select    <= 1'b1;
            end
            OP_ACK:   i_out_ack <= 1'b1;
            default:  ;
        endcase
        @(posedge i_clk);
        i_init      <= 1'b0;
        i_start     <= 1'b0;
        i_draw_two  <= 1'b0;
        i_draw_four <= 1'b0;
        i_select    <= 1'b0;
        i_out_ack   <= 1'b0;
        if (s.op == OP_PRESS) begin
            repeat (s.hold - 1) @(posedge i_clk);  // button stays down
            i_left  <= 1'b0;
            i_right <= 1'b0;
        end else if (s.op == OP_CHECK) begin
            repeat (s.hold) @(posedge i_clk);
        end
        if (expect_draw) begin
            wait_draw_idle();
        end else begin
            @(negedge i_clk);
        end
    endtask

    task automatic update_model(step_t s);
        case (s.op)
            OP_DEAL, OP_START: begin
                for (int k = 0; k < 7; k++) begin
                    if (s.deck[k] != CARD_NONE) model_insert(s.deck[k]);
                end
            end
            OP_PRESS: cur_index = s.exp_index;
            OP_SELECT: begin
                if (!out_now && cur_index == hand_q.size()) begin
                    model_insert(s.deck[0]);  // draw slot takes one card
                end else if (!out_now && s.exp_out) begin
                    exp_card = hand_q[cur_index];
                    hand_q.delete(cur_index);
                    out_now = 1'b1;
                end
                if (cur_index > hand_q.size()) cur_index = hand_q.size();
            end
            OP_ACK:   out_now = 1'b0;
            default:  ;
        endcase
    endtask

    task automatic compare_outputs();
        check_flag("o_draw", o_draw, 1'b0);
        check_flag("o_out", o_out, out_now);
        if (out_now) check_card("o_out_card", o_out_card, exp_card);
        check_hand("o_hands", o_hands, model_hand());
        check_count("o_index", o_index, cur_index);
        check_flag("o_full", o_full, hand_q.size() == HAND_MAX);
    endtask

    initial begin
        int n;
        i_init      = 1'b0;
        i_start     = 1'b0;
        i_draw_two  = 1'b0;
        i_draw_four = 1'b0;
        i_select    = 1'b0;
        i_left      = 1'b0;
        i_right     = 1'b0;
        i_out_ack   = 1'b0;
        i_prev_card = CARD_NONE;
        cur_index   = '0;
        out_now     = 1'b0;
        exp_card    = CARD_NONE;
        steps = '{
            '{OP_DEAL,   3'd0, 4'd0, CARD_NONE, DECK_DEAL, 1'b0, 4'd0},
            '{OP_PRESS,  3'd0, 4'd3, CARD_NONE, NO_DECK,   1'b0, 4'd7},  // wrap to draw slot
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd1},
            '{OP_PRESS,  3'd1, 4'd5, CARD_NONE, NO_DECK,   1'b0, 4'd2},  // held but moves once
            '{OP_START,  3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_SELECT, 3'd0, 4'd0, 6'h02,     NO_DECK,   1'b0, 4'd0},  // yellow 7 on red 2
            '{OP_PRESS,  3'd0, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd1},
            '{OP_SELECT, 3'd0, 4'd0, 6'h02,     NO_DECK,   1'b1, 4'd0},  // colour match
            '{OP_CHECK,  3'd0, 4'd4, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_SELECT, 3'd0, 4'd0, 6'h12,     NO_DECK,   1'b1, 4'd0},  // back-pressure
            '{OP_ACK,    3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_START,  3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_SELECT, 3'd0, 4'd0, 6'h37,     NO_DECK,   1'b1, 4'd0},  // value match
            '{OP_ACK,    3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_START,  3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd2},
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd3},
            '{OP_SELECT, 3'd0, 4'd0, 6'h11,     NO_DECK,   1'b1, 4'd0},  // wild
            '{OP_ACK,    3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_START,  3'd2, 4'd0, CARD_NONE, DECK_TWO,  1'b0, 4'd0},
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd4},
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd5},
            '{OP_PRESS,  3'd1, 4'd1, CARD_NONE, NO_DECK,   1'b0, 4'd6},
            '{OP_SELECT, 3'd0, 4'd0, CARD_NONE, DECK_ONE,  1'b0, 4'd0},  // draw slot
            '{OP_START,  3'd4, 4'd0, CARD_NONE, DECK_FOUR, 1'b0, 4'd0},
            '{OP_SELECT, 3'd0, 4'd0, 6'h23,     NO_DECK,   1'b1, 4'd0},
            '{OP_ACK,    3'd0, 4'd0, CARD_NONE, NO_DECK,   1'b0, 4'd0},
            '{OP_DEAL,   3'd0, 4'd0, CARD_NONE, DECK_FILL, 1'b0, 4'd0},  // fills to 15
            '{OP_CHECK,  3'd0, 4'd3, CARD_NONE, NO_DECK,   1'b0, 4'd0}
        };
        n = 0;
        while (i_rst_n !== 1'b1) begin
            if (n == RESET_TIMEOUT) begin
                stop_with_failure("reset was never released");
            end
            n++;
            @(posedge i_clk);
        end
        @(negedge i_clk);
        compare_outputs();
        check_card("o_out_card", o_out_card, CARD_NONE);
        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(steps[i]);
            update_model(steps[i]);
            compare_outputs();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;  // period 10
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// ==== verilog/uno_player.sv ====
module uno_player #(
    parameter int HAND_SIZE  = 15,
    parameter int INIT_CARDS = 7
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_init,
    input  logic             i_start,
    input  logic             i_draw_two,
    input  logic             i_draw_four,
    input  logic             i_select,
    input  logic             i_left,
    input  logic             i_right,
    input  logic             i_drawn,
    input  logic             i_out_ack,
    input  card_pkg::card_t  i_prev_card,
    input  card_pkg::card_t  i_drawn_card,
    output logic             o_draw,
    output logic             o_out,
    output card_pkg::card_t  o_out_card,
    output card_pkg::hand_t  o_hands,
    output logic             o_full,
    output card_pkg::count_t o_index
);
    import card_pkg::*;
    import player_pkg::*;

    bank_cmd_t bank_cmd;
    count_t    hand_count;
    card_t     sel_card;   // card under the cursor

    turn_ctrl #(
        .INIT_CARDS (INIT_CARDS)
    ) u_turn_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_select     (i_select),
        .i_drawn      (i_drawn),
        .i_out_ack    (i_out_ack),
        .i_prev_card  (i_prev_card),
        .i_drawn_card (i_drawn_card),
        .i_sel_card   (sel_card),
        .i_index      (o_index),
        .i_count      (hand_count),
        .i_full       (o_full),
        .o_cmd        (bank_cmd),
        .o_draw       (o_draw),
        .o_out        (o_out),
        .o_out_card   (o_out_card)
    );

    hand_bank #(
        .HAND_SIZE (HAND_SIZE)
    ) u_hand_bank (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (bank_cmd),
        .i_index    (o_index),
        .o_hands    (o_hands),
        .o_count    (hand_count),
        .o_full     (o_full),
        .o_sel_card (sel_card)
    );

    hand_cursor #(
        .HAND_SIZE (HAND_SIZE)
    ) u_hand_cursor (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_left  (i_left),
        .i_right (i_right),
        .i_count (hand_count),
        .o_index (o_index)
    );

endmodule

// ==== verilog/turn_ctrl.sv ====
module turn_ctrl #(
    parameter int INIT_CARDS = 7
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_init,
    input  logic                  i_start,
    input  logic                  i_draw_two,
    input  logic                  i_draw_four,
    input  logic                  i_select,
    input  logic                  i_drawn,
    input  logic                  i_out_ack,
    input  card_pkg::card_t       i_prev_card,
    input  card_pkg::card_t       i_drawn_card,
    input  card_pkg::card_t       i_sel_card,
    input  card_pkg::count_t      i_index,
    input  card_pkg::count_t      i_count,
    input  logic                  i_full,
    output player_pkg::bank_cmd_t o_cmd,
    output logic                  o_draw,
    output logic                  o_out,
    output card_pkg::card_t       o_out_card
);
    import card_pkg::*;
    import player_pkg::*;

    turn_state_e state_r;
    turn_state_e state_nxt;
    count_t      draw_left_r;
    count_t      draw_left_nxt;
    logic        to_play_r;     // penalty draw goes on to play
    logic        to_play_nxt;
    card_t       out_card_r;
    card_t       out_card_nxt;
    logic        legal;
    logic        take;

    assign legal = (i_sel_card.value == VAL_WILD) || (i_sel_card.value == VAL_WILD4)
                || (i_sel_card.colour == i_prev_card.colour)
                || (i_sel_card.value == i_prev_card.value);

    // a full hand cancels whatever is still wanted
    assign o_draw     = ((state_r == ST_DRAW) || (state_r == ST_NOCARD)) && !i_full;
    assign take       = o_draw && i_drawn;
    assign o_out      = (state_r == ST_OUT);
    assign o_out_card = out_card_r;

    always_comb begin
        state_nxt     = state_r;
        draw_left_nxt = draw_left_r;
        to_play_nxt   = to_play_r;
        out_card_nxt  = out_card_r;
        o_cmd.insert  = take;
        o_cmd.remove  = 1'b0;
        o_cmd.card    = i_drawn_card;
        o_cmd.slot    = i_index;
        case (state_r)
            ST_IDLE: begin
                if (i_start) begin
                    to_play_nxt = 1'b1;
                    if (i_draw_two) begin
                        draw_left_nxt = count_t'(2);
                        state_nxt     = ST_DRAW;
                    end else if (i_draw_four) begin
                        draw_left_nxt = count_t'(4);
                        state_nxt     = ST_DRAW;
                    end else begin
                        state_nxt = ST_PLAY;
                    end
                end else if (i_init) begin
                    to_play_nxt   = 1'b0;  // deal returns to idle
                    draw_left_nxt = count_t'(INIT_CARDS);
                    state_nxt     = ST_DRAW;
                end
            end
            ST_DRAW: begin
                if (i_full || (take && draw_left_r == count_t'(1))) begin
                    draw_left_nxt = '0;
                    state_nxt     = to_play_r ? ST_PLAY : ST_IDLE;
                end else if (take) begin
                    draw_left_nxt = draw_left_r - 1'b1;
                end
            end
            ST_PLAY: begin
                if (i_select) begin
                    if (i_index == i_count) begin
                        state_nxt = ST_NOCARD;
                    end else if ((i_index < i_count) && legal) begin
                        o_cmd.remove = 1'b1;
                        out_card_nxt = i_sel_card;
                        state_nxt    = ST_OUT;
                    end
                end
            end
            ST_OUT: begin
                if (i_out_ack) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_NOCARD: begin
                if (take || i_full) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= ST_IDLE;
            draw_left_r <= '0;
            to_play_r   <= 1'b0;
            out_card_r  <= CARD_NONE;
        end else begin
            state_r     <= state_nxt;
            draw_left_r <= draw_left_nxt;
            to_play_r   <= to_play_nxt;
            out_card_r  <= out_card_nxt;
        end
    end

endmodule

// ==== verilog/hand_cursor.sv ====
module hand_cursor #(
    parameter int HAND_SIZE = card_pkg::HAND_MAX
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_left,
    input  logic             i_right,
    input  card_pkg::count_t i_count,
    output card_pkg::count_t o_index
);
    import card_pkg::*;

    logic   left_q;
    logic   right_q;
    logic   left_rise;
    logic   right_rise;
    count_t top;
    count_t index_r;
    count_t index_nxt;

    assign left_rise  = i_left && !left_q;
    assign right_rise = i_right && !right_q;

    // draw slot sits right after the last card
    assign top = (i_count > count_t'(HAND_SIZE)) ? count_t'(HAND_SIZE) : i_count;

    always_comb begin
        index_nxt = index_r;
        if (index_r > top) begin
            index_nxt = top;  // hand shrank under the cursor
        end else if (left_rise && !right_rise) begin
            index_nxt = (index_r == '0) ? top : index_r - 1'b1;
        end else if (right_rise && !left_rise) begin
            index_nxt = (index_r == top) ? '0 : index_r + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
            index_r <= '0;
        end else begin
            left_q  <= i_left;
            right_q <= i_right;
            index_r <= index_nxt;
        end
    end

    assign o_index = index_r;

endmodule

// ==== verilog/hand_bank.sv ====
module hand_bank #(
    parameter int HAND_SIZE = card_pkg::HAND_MAX
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  player_pkg::bank_cmd_t i_cmd,
    input  card_pkg::count_t      i_index,
    output card_pkg::hand_t       o_hands,
    output card_pkg::count_t      o_count,
    output logic                  o_full,
    output card_pkg::card_t       o_sel_card
);
    import card_pkg::*;

    hand_t  slots_r;
    hand_t  slots_nxt;
    count_t grp_cnt_r   [GRP_NUM];
    count_t grp_cnt_nxt [GRP_NUM];
    count_t total;
    count_t ins_pos;
    group_e ins_grp;
    group_e rem_grp;
    logic   do_insert;
    logic   do_remove;

    // index 15 is the draw slot when the hand is full
    function automatic card_t slot_card(hand_t hand, count_t idx);
        if (idx < HAND_MAX) begin
            return hand[idx];
        end
        return CARD_NONE;
    endfunction

    assign ins_grp = group_of(i_cmd.card);
    assign rem_grp = group_of(slot_card(slots_r, i_cmd.slot));

    // hand size and end of the target group in one pass
    always_comb begin
        total   = '0;
        ins_pos = '0;
        for (int g = 0; g < GRP_NUM; g++) begin
            total = total + grp_cnt_r[g];
            if (g <= int'(ins_grp)) begin
                ins_pos = ins_pos + grp_cnt_r[g];
            end
        end
    end

    assign o_count   = total;
    assign o_full    = (total == count_t'(HAND_SIZE));
    assign do_insert = i_cmd.insert && !o_full;           // drop inserts when full
    assign do_remove = i_cmd.remove && (i_cmd.slot < total);

    always_comb begin
        slots_nxt   = slots_r;
        grp_cnt_nxt = grp_cnt_r;
        if (do_insert) begin
            for (int s = 1; s < HAND_SIZE; s++) begin
                if (s > ins_pos) begin
                    slots_nxt[s] = slots_r[s-1];  // make room behind the group
                end
            end
            slots_nxt[ins_pos]   = i_cmd.card;
            grp_cnt_nxt[ins_grp] = grp_cnt_r[ins_grp] + 1'b1;
        end else if (do_remove) begin
            for (int s = 0; s < HAND_SIZE - 1; s++) begin
                if (s >= i_cmd.slot) begin
                    slots_nxt[s] = slots_r[s+1];  // close the gap
                end
            end
            slots_nxt[HAND_SIZE-1] = CARD_NONE;
            grp_cnt_nxt[rem_grp]   = grp_cnt_r[rem_grp] - 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < HAND_MAX; s++) begin
                slots_r[s] <= CARD_NONE;
            end
            for (int g = 0; g < GRP_NUM; g++) begin
                grp_cnt_r[g] <= '0;
            end
        end else begin
            slots_r   <= slots_nxt;
            grp_cnt_r <= grp_cnt_nxt;
        end
    end

    assign o_hands    = slots_r;
    assign o_sel_card = slot_card(slots_r, i_index);

endmodule

// ==== verilog/player_pkg.sv ====
package player_pkg;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_DRAW   = 3'd1,  // deal or penalty cards
        ST_PLAY   = 3'd2,
        ST_OUT    = 3'd3,  // waiting for deck ack
        ST_NOCARD = 3'd4   // single draw from the draw slot
    } turn_state_e;

    // one command per cycle, insert wins if both set
    typedef struct packed {
        logic              insert;
        logic              remove;
        card_pkg::card_t   card;   // card to insert
        card_pkg::count_t  slot;   // slot to remove
    } bank_cmd_t;

endpackage

// ==== verilog/card_pkg.sv ====
package card_pkg;

    typedef enum logic [1:0] {
        COL_RED    = 2'd0,
        COL_YELLOW = 2'd1,
        COL_GREEN  = 2'd2,
        COL_BLUE   = 2'd3
    } colour_e;

    // value 0-9 numbers, 10 skip, 11 reverse, 12 draw two
    typedef struct packed {
        colour_e    colour;
        logic [3:0] value;
    } card_t;

    localparam logic [3:0] VAL_WILD  = 4'd13;
    localparam logic [3:0] VAL_WILD4 = 4'd14;

    localparam card_t CARD_NONE = '{colour: COL_BLUE, value: 4'hf};  // empty slot

    typedef enum logic [2:0] {
        GRP_RED,
        GRP_YELLOW,
        GRP_GREEN,
        GRP_BLUE,
        GRP_WILD,
        GRP_WILD4
    } group_e;

    localparam int GRP_NUM = 6;

    localparam int HAND_MAX = 15;

    typedef card_t [HAND_MAX-1:0] hand_t;  // slot 0 in the low bits
    typedef logic [$clog2(HAND_MAX+1)-1:0] count_t;

    function automatic group_e group_of(card_t card);
        if (card.value == VAL_WILD) begin
            return GRP_WILD;
        end else if (card.value == VAL_WILD4) begin
            return GRP_WILD4;
        end
        return group_e'({1'b0, card.colour});  // colour groups come first
    endfunction

endpackage
